// File: hw/composite_timing.sv
`timescale 1ns/1ps

module composite_timing (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [video_pkg::RGB_W-1:0]        palette_rgb_data,
    output logic                               next_pixel,
    output logic [video_pkg::LINE_IDX_W-1:0]   display_line_idx,
    output logic                               start_of_screen,
    output logic                               end_of_screen,
    output logic                               start_of_line,
    output logic [video_pkg::LUMA_W-1:0]       luma,
    output logic                               sync_n,
    output logic [video_pkg::CHROMA_W-1:0]     chroma
);

    logic [$clog2(video_pkg::H_TOTAL)-1:0]      hcnt;
    logic [$clog2(video_pkg::V_HALF_LINES)-1:0] vcnt;
    logic                                       field;
    logic [video_pkg::LINE_IDX_W-2:0]           field_line_cnt;

    logic h_hsync_pulse;
    logic h_vsync_pulse;
    logic h_eq_pulse;
    logic h_burst;
    logic h_active;
    logic h_last;
    logic h_half_last;
    logic v_sync;
    logic v_eq;
    logic v_active;
    logic v_frame_last;
    logic mod_sync_n;

    // true when the half-line index falls in a six half-line segment
    function automatic logic in_seg(
        input logic [$clog2(video_pkg::V_HALF_LINES)-1:0] v,
        input int                                         first
    );
        return (v >= first) && (v < first + video_pkg::V_SEG_LEN);
    endfunction

    // horizontal decode
    assign h_hsync_pulse = hcnt < video_pkg::H_SYNC;
    assign h_vsync_pulse = (hcnt < video_pkg::H_VSYNC_PULSE_LEN) ||
        (hcnt >= video_pkg::H_HALF &&
         hcnt < video_pkg::H_HALF + video_pkg::H_VSYNC_PULSE_LEN);
    assign h_eq_pulse = (hcnt < video_pkg::H_EQ_PULSE_LEN) ||
        (hcnt >= video_pkg::H_HALF &&
         hcnt < video_pkg::H_HALF + video_pkg::H_EQ_PULSE_LEN);
    assign h_burst = (hcnt >= video_pkg::H_BURST_START) &&
        (hcnt < video_pkg::H_BURST_END);
    assign h_active = (hcnt >= video_pkg::H_SYNC + video_pkg::H_BACK_PORCH) &&
        (hcnt < video_pkg::H_SYNC + video_pkg::H_BACK_PORCH + video_pkg::H_ACTIVE);
    assign h_last      = hcnt == video_pkg::H_TOTAL - 1;
    assign h_half_last = (hcnt == video_pkg::H_HALF - 1) || h_last;

    // vertical decode
    assign v_sync = in_seg(vcnt, video_pkg::V_SYNC1) || in_seg(vcnt, video_pkg::V_SYNC2);
    assign v_eq = in_seg(vcnt, video_pkg::V_EQ1) || in_seg(vcnt, video_pkg::V_EQ2) ||
        in_seg(vcnt, video_pkg::V_EQ3) || in_seg(vcnt, video_pkg::V_EQ4);
    assign v_active =
        (vcnt >= video_pkg::V_ACT1_FIRST && vcnt <= video_pkg::V_ACT1_LAST) ||
        (vcnt >= video_pkg::V_ACT2_FIRST && vcnt <= video_pkg::V_ACT2_LAST);
    assign v_frame_last = vcnt == video_pkg::V_HALF_LINES - 1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            hcnt <= h_last ? '0 : hcnt + 1'b1;
            if (h_half_last) begin
                vcnt <= v_frame_last ? '0 : vcnt + 1'b1;
            end
        end
    end

    // field 0 is the even field, restarted at each field boundary
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            field          <= 1'b0;
            field_line_cnt <= '0;
        end else begin
            if (h_half_last && v_frame_last) begin
                field          <= 1'b0;
                field_line_cnt <= '0;
            end else if (h_half_last && vcnt == video_pkg::V_FIELD1_LAST) begin
                field          <= 1'b1;
                field_line_cnt <= '0;
            end else if (h_last) begin
                field_line_cnt <= field_line_cnt + 1'b1;
            end
        end
    end

    assign display_line_idx = {field_line_cnt, field};

    assign start_of_line = h_last;
    // last line end ahead of the first active half-line of each field
    assign start_of_screen = h_last &&
        (vcnt == video_pkg::V_ACT1_FIRST - 1 || vcnt == video_pkg::V_ACT2_FIRST - 1);
    assign end_of_screen = h_half_last &&
        (vcnt == video_pkg::V_FIELD1_LAST || v_frame_last);

    // sync shape per half-line type
    always_comb begin
        if (v_sync) begin
            mod_sync_n = !h_vsync_pulse;
        end else if (v_eq) begin
            mod_sync_n = !h_eq_pulse;
        end else begin
            mod_sync_n = !h_hsync_pulse;
        end
    end

    // one pixel every other clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_pixel <= 1'b0;
        end else if (start_of_line) begin
            next_pixel <= 1'b0;
        end else if (h_active) begin
            next_pixel <= !next_pixel;
        end
    end

    video_modulator modulator_i (
        .clk       (clk),
        .rst       (rst),
        .r         (palette_rgb_data[11:8]),
        .g         (palette_rgb_data[7:4]),
        .b         (palette_rgb_data[3:0]),
        .burst     (v_active && h_burst),
        .active    (v_active && h_active),
        .sync_n_in (mod_sync_n),
        .luma      (luma),
        .sync_n    (sync_n),
        .chroma    (chroma)
    );

endmodule

// File: hw/composite_video_top.sv
`timescale 1ns/1ps

module composite_video_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pal_wr,
    input  logic [video_pkg::PAL_IDX_W-1:0]  pal_addr,
    input  logic [video_pkg::RGB_W-1:0]      pal_data,
    input  logic                             pix_wr,
    input  logic [video_pkg::PIX_ADDR_W-1:0] pix_addr,
    input  logic [video_pkg::PAL_IDX_W-1:0]  pix_data,
    output logic [video_pkg::LINE_IDX_W-1:0] display_line_idx,
    output logic                             start_of_line,
    output logic                             start_of_screen,
    output logic                             end_of_screen,
    output logic [video_pkg::LUMA_W-1:0]     luma,
    output logic                             sync_n,
    output logic [video_pkg::CHROMA_W-1:0]   chroma
);

    logic                            next_pixel;
    logic [video_pkg::PAL_IDX_W-1:0] pal_idx;
    logic [video_pkg::RGB_W-1:0]     palette_rgb_data;

    line_buffer line_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .pix_wr        (pix_wr),
        .pix_addr      (pix_addr),
        .pix_data      (pix_data),
        .next_pixel    (next_pixel),
        .start_of_line (start_of_line),
        .pal_idx       (pal_idx)
    );

    palette_ram palette_ram_i (
        .clk              (clk),
        .pal_wr           (pal_wr),
        .pal_addr         (pal_addr),
        .pal_data         (pal_data),
        .pal_idx          (pal_idx),
        .palette_rgb_data (palette_rgb_data)
    );

    composite_timing composite_timing_i (
        .clk              (clk),
        .rst              (rst),
        .palette_rgb_data (palette_rgb_data),
        .next_pixel       (next_pixel),
        .display_line_idx (display_line_idx),
        .start_of_screen  (start_of_screen),
        .end_of_screen    (end_of_screen),
        .start_of_line    (start_of_line),
        .luma             (luma),
        .sync_n           (sync_n),
        .chroma           (chroma)
    );

endmodule

// File: hw/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pix_wr,
    input  logic [video_pkg::PIX_ADDR_W-1:0] pix_addr,
    input  logic [video_pkg::PAL_IDX_W-1:0]  pix_data,
    input  logic                             next_pixel,
    input  logic                             start_of_line,
    output logic [video_pkg::PAL_IDX_W-1:0]  pal_idx
);

    logic [video_pkg::PAL_IDX_W-1:0]  idx_mem [video_pkg::PIXELS_PER_LINE];
    logic [video_pkg::PIX_ADDR_W-1:0] rd_ptr;
    logic                             rd_at_end;

    // host writes past the line are dropped
    always_ff @(posedge clk) begin
        if (pix_wr && pix_addr < video_pkg::PIXELS_PER_LINE) begin
            idx_mem[pix_addr] <= pix_data;
        end
    end

    // hold on the last pixel until the next line starts
    assign rd_at_end = rd_ptr == video_pkg::PIXELS_PER_LINE - 1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (start_of_line) begin
            rd_ptr <= '0;
        end else if (next_pixel && !rd_at_end) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        pal_idx <= idx_mem[rd_ptr];
    end

endmodule

// File: hw/palette_ram.sv
`timescale 1ns/1ps

module palette_ram (
    input  logic                            clk,
    input  logic                            pal_wr,
    input  logic [video_pkg::PAL_IDX_W-1:0] pal_addr,
    input  logic [video_pkg::RGB_W-1:0]     pal_data,
    input  logic [video_pkg::PAL_IDX_W-1:0] pal_idx,
    output logic [video_pkg::RGB_W-1:0]     palette_rgb_data
);

    // 12-bit colours, r in the top nibble
    logic [video_pkg::RGB_W-1:0] colour_mem [video_pkg::PAL_ENTRIES];

    always_ff @(posedge clk) begin
        if (pal_wr) begin
            colour_mem[pal_addr] <= pal_data;
        end
    end

    // read before write on a shared address
    always_ff @(posedge clk) begin
        palette_rgb_data <= colour_mem[pal_idx];
    end

endmodule

// File: hw/video_modulator.sv
`timescale 1ns/1ps

module video_modulator (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [3:0]                     r,
    input  logic [3:0]                     g,
    input  logic [3:0]                     b,
    input  logic                           burst,
    input  logic                           active,
    input  logic                           sync_n_in,
    output logic [video_pkg::LUMA_W-1:0]   luma,
    output logic                           sync_n,
    output logic [video_pkg::CHROMA_W-1:0] chroma
);

    logic [7:0]        y_sum;
    logic [3:0]        y;
    logic signed [5:0] u_diff;
    logic signed [5:0] v_diff;

    logic [3:0]        y_q;
    logic signed [5:0] u_q;
    logic signed [5:0] v_q;
    logic              burst_q;
    logic              active_q;
    logic              sync_q;

    logic [video_pkg::PHASE_W-1:0]  phase;
    logic                           sin_neg;
    logic                           cos_neg;
    logic signed [5:0]              u_term;
    logic signed [5:0]              v_term;
    logic signed [6:0]              mix;
    logic signed [6:0]              scaled;
    logic [video_pkg::CHROMA_W-1:0] chroma_ofs;
    logic [video_pkg::CHROMA_W-1:0] chroma_next;
    logic [video_pkg::LUMA_W-1:0]   luma_next;

    // luma weights 5/16, 9/16, 2/16
    assign y_sum  = 8'd5 * r + 8'd9 * g + 8'd2 * b;
    assign y      = y_sum[7:4];
    assign u_diff = $signed({2'b00, b}) - $signed({2'b00, y});
    assign v_diff = $signed({2'b00, r}) - $signed({2'b00, y});

    // first stage, colour differences
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            burst_q  <= 1'b0;
            active_q <= 1'b0;
            sync_q   <= 1'b0;
        end else begin
            burst_q  <= burst;
            active_q <= active;
            sync_q   <= sync_n_in;
        end
    end

    always_ff @(posedge clk) begin
        y_q <= y;
        u_q <= u_diff;
        v_q <= v_diff;
    end

    // free-running subcarrier
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + video_pkg::PHASE_STEP;
        end
    end

    // square-wave sine and cosine signs from the top two phase bits
    assign sin_neg = phase[video_pkg::PHASE_W-1];
    assign cos_neg = phase[video_pkg::PHASE_W-1] ^ phase[video_pkg::PHASE_W-2];

    assign u_term = sin_neg ? -u_q : u_q;
    assign v_term = cos_neg ? -v_q : v_q;
    assign mix    = u_term + v_term;
    assign scaled = mix >>> 1;

    always_comb begin
        if (burst_q) begin
            // burst sits opposite the u axis
            chroma_ofs = sin_neg ? video_pkg::BURST_AMPL : -video_pkg::BURST_AMPL;
        end else if (active_q) begin
            if (scaled > 7'sd7) begin
                chroma_ofs = 4'd7;
            end else if (scaled < -7'sd8) begin
                chroma_ofs = 4'd8;
            end else begin
                chroma_ofs = scaled[3:0];
            end
        end else begin
            chroma_ofs = '0;
        end
    end

    // two's complement offset around mid level
    assign chroma_next = video_pkg::CHROMA_ZERO + chroma_ofs;

    always_comb begin
        if (!sync_q) begin
            luma_next = '0;
        end else if (!active_q) begin
            luma_next = video_pkg::LUMA_BLANK;
        end else begin
            luma_next = video_pkg::LUMA_BLANK + {1'b0, y_q};
        end
    end

    // second stage, output registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            luma   <= '0;
            sync_n <= 1'b0;
            chroma <= video_pkg::CHROMA_ZERO;
        end else begin
            luma   <= luma_next;
            sync_n <= sync_q;
            chroma <= chroma_next;
        end
    end

endmodule

// File: hw/video_pkg.sv
package video_pkg;

    // horizontal timing in clocks
    localparam int H_SYNC        = 118;
    localparam int H_BACK_PORCH  = 152;
    localparam int H_ACTIVE      = 1280;
    localparam int H_FRONT_PORCH = 38;
    localparam int H_TOTAL       = H_SYNC + H_BACK_PORCH + H_ACTIVE + H_FRONT_PORCH;
    localparam int H_HALF        = H_TOTAL / 2;

    localparam int H_VSYNC_PULSE_LEN = 678;
    localparam int H_EQ_PULSE_LEN    = 58;
    localparam int H_BURST_START     = 132;
    localparam int H_BURST_END       = 196;

    // vertical timing in half-lines
    localparam int V_HALF_LINES  = 1050;
    localparam int V_SEG_LEN     = 6;
    localparam int V_EQ1         = 0;
    localparam int V_SYNC1       = 6;
    localparam int V_EQ2         = 12;
    localparam int V_EQ3         = 525;
    localparam int V_SYNC2       = 531;
    localparam int V_EQ4         = 537;
    localparam int V_ACT1_FIRST  = 42;
    localparam int V_ACT1_LAST   = 521;
    localparam int V_ACT2_FIRST  = 568;
    localparam int V_ACT2_LAST   = 1047;
    localparam int V_FIELD1_LAST = 524;

    // pixel source
    localparam int PIXELS_PER_LINE = 640;
    localparam int PIX_ADDR_W      = 10;
    localparam int PAL_ENTRIES     = 256;
    localparam int PAL_IDX_W       = 8;
    localparam int RGB_W           = 12;
    localparam int LINE_IDX_W      = 9;

    // output levels
    localparam int LUMA_W   = 5;
    localparam int CHROMA_W = 4;
    localparam logic [LUMA_W-1:0]   LUMA_BLANK  = 5'd8;
    localparam logic [CHROMA_W-1:0] CHROMA_ZERO = 4'd8;
    localparam logic [CHROMA_W-1:0] BURST_AMPL  = 4'd3;

    // subcarrier, about 3.58 MHz from a 25 MHz clock
    localparam int PHASE_W = 8;
    localparam logic [PHASE_W-1:0] PHASE_STEP = 8'd37;

endpackage

// File: list.f
hw/video_pkg.sv
hw/palette_ram.sv
hw/line_buffer.sv
hw/video_modulator.sv
hw/composite_timing.sv
hw/composite_video_top.sv
verification/composite_video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module composite_video_tb -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verification/composite_video_tb.sv
`timescale 1ns/1ps

module composite_video_tb;

    localparam int CLK_PERIOD = 20;
    localparam int MID_FIRST = video_pkg::H_SYNC + video_pkg::H_BACK_PORCH +
        video_pkg::H_ACTIVE / 4;
    localparam int MID_LAST = video_pkg::H_SYNC + video_pkg::H_BACK_PORCH +
        3 * video_pkg::H_ACTIVE / 4;
    localparam int PORCH_FIRST = video_pkg::H_SYNC + 10;
    localparam int PORCH_LAST = video_pkg::H_SYNC + video_pkg::H_BACK_PORCH - 10;
    localparam int FRONT_FIRST = video_pkg::H_SYNC + video_pkg::H_BACK_PORCH +
        video_pkg::H_ACTIVE + 8;
    // one field is half a frame of half-lines
    localparam longint FIELD_CLOCKS =
        longint'(video_pkg::V_HALF_LINES / 2) * video_pkg::H_TOTAL / 2;
    localparam longint WATCHDOG_CYCLES =
        2 * longint'(video_pkg::V_HALF_LINES / 2) * video_pkg::H_TOTAL +
        20 * video_pkg::H_TOTAL;
    // grey line uses a few palette entries, so most grey levels stay unused
    localparam int GREY_ENTRIES = 8;

    logic        clk;
    logic        rst;
    logic        pal_wr;
    logic [7:0]  pal_addr;
    logic [11:0] pal_data;
    logic        pix_wr;
    logic [9:0]  pix_addr;
    logic [7:0]  pix_data;
    logic [8:0]  display_line_idx;
    logic        start_of_line;
    logic        start_of_screen;
    logic        end_of_screen;
    logic [4:0]  luma;
    logic        sync_n;
    logic [3:0]  chroma;

    int          errors = 0;
    longint      cycle_count = 0;
    logic [11:0] palette_model [video_pkg::PAL_ENTRIES];
    logic [7:0]  line_model [video_pkg::PIXELS_PER_LINE];

    composite_video_top composite_video_top_i (
        .clk              (clk),
        .rst              (rst),
        .pal_wr           (pal_wr),
        .pal_addr         (pal_addr),
        .pal_data         (pal_data),
        .pix_wr           (pix_wr),
        .pix_addr         (pix_addr),
        .pix_data         (pix_data),
        .display_line_idx (display_line_idx),
        .start_of_line    (start_of_line),
        .start_of_screen  (start_of_screen),
        .end_of_screen    (end_of_screen),
        .luma             (luma),
        .sync_n           (sync_n),
        .chroma           (chroma)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within two frames");
        $display("Finished with errors");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, actual,
                     expected);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // blank level plus Y = (5r + 9g + 2b) / 16
    function automatic int luma_level(input logic [11:0] rgb);
        int y;
        y = (5 * rgb[11:8] + 9 * rgb[7:4] + 2 * rgb[3:0]) / 16;
        return video_pkg::LUMA_BLANK + y;
    endfunction

    task automatic write_palette(input logic [7:0] addr, input logic [11:0] rgb);
        @(negedge clk);
        pal_wr   = 1'b1;
        pal_addr = addr;
        pal_data = rgb;
        @(negedge clk);
        pal_wr = 1'b0;
    endtask

    task automatic write_pixel(input logic [9:0] addr, input logic [7:0] idx);
        @(negedge clk);
        pix_wr   = 1'b1;
        pix_addr = addr;
        pix_data = idx;
        @(negedge clk);
        pix_wr = 1'b0;
    endtask

    task automatic wait_line_start();
        do @(negedge clk); while (!start_of_line);
    endtask

    task automatic wait_screen_start();
        do @(negedge clk); while (!start_of_screen);
    endtask

    task automatic check_line_period();
        int clocks;
        int pixels;
        wait_line_start();
        repeat (3) begin
            clocks = 0;
            pixels = 0;
            do begin
                @(negedge clk);
                clocks++;
                if (composite_video_top_i.next_pixel) begin
                    pixels++;
                end
            end while (!start_of_line && clocks < 2 * video_pkg::H_TOTAL);
            check_value("start_of_line period", clocks, video_pkg::H_TOTAL);
            check_value("next_pixel count", pixels, video_pkg::PIXELS_PER_LINE);
        end
    endtask

    task automatic check_field_structure();
        logic [8:0] prev_idx;
        logic [8:0] next_idx;
        logic       line_end;
        logic       field_bit [2];
        longint     eos_cycle [2];
        for (int f = 0; f < 2; f++) begin
            wait_screen_start();
            // start_of_screen sits on a line end
            check_value("start_of_line at start_of_screen", start_of_line, 1);
            prev_idx = display_line_idx;
            line_end = 1'b1;
            do begin
                @(negedge clk);
                // the index may only move right after a line end
                next_idx = line_end ? prev_idx + 9'd2 : prev_idx;
                check_value("display_line_idx", display_line_idx, next_idx);
                prev_idx = display_line_idx;
                line_end = start_of_line;
            end while (!end_of_screen);
            field_bit[f] = display_line_idx[0];
            eos_cycle[f] = cycle_count;
        end
        check_value("display_line_idx[0] of second field", field_bit[1], !field_bit[0]);
        check_value("end_of_screen spacing", eos_cycle[1] - eos_cycle[0], FIELD_CLOCKS);
    endtask

    task automatic load_grey_line();
        logic [3:0] level;
        for (int i = 0; i < video_pkg::PAL_ENTRIES; i++) begin
            level = 4'($urandom());
            palette_model[i] = {level, level, level};
            write_palette(8'(i), palette_model[i]);
        end
        for (int i = 0; i < video_pkg::PIXELS_PER_LINE; i++) begin
            line_model[i] = 8'($urandom() % GREY_ENTRIES);
            write_pixel(10'(i), line_model[i]);
        end
    endtask

    task automatic check_grey_luma();
        bit allowed [32];
        allowed = '{default: 1'b0};
        for (int i = 0; i < video_pkg::PIXELS_PER_LINE; i++) begin
            allowed[luma_level(palette_model[line_model[i]])] = 1'b1;
        end
        wait_screen_start();
        wait_line_start();
        for (int k = 1; k <= video_pkg::H_TOTAL; k++) begin
            @(negedge clk);
            if (k >= MID_FIRST && k <= MID_LAST) begin
                if (!allowed[luma]) begin
                    report_error($sformatf("luma %0d matches no grey of the written line",
                                           luma));
                end
                check_value("chroma", chroma, video_pkg::CHROMA_ZERO);
                check_value("sync_n", sync_n, 1);
            end
        end
    endtask

    // starts aligned on a line end, ends on one
    task automatic check_hsync_width();
        int low_total;
        int run;
        int longest;
        repeat (3) begin
            low_total = 0;
            run = 0;
            longest = 0;
            for (int k = 1; k <= video_pkg::H_TOTAL; k++) begin
                @(negedge clk);
                if (!sync_n) begin
                    low_total++;
                    run++;
                    if (run > longest) begin
                        longest = run;
                    end
                end else begin
                    run = 0;
                end
            end
            check_value("start_of_line", start_of_line, 1);
            check_value("sync_n low clocks", low_total, video_pkg::H_SYNC);
            check_value("sync_n low run", longest, video_pkg::H_SYNC);
        end
    endtask

    task automatic check_blanking_burst();
        logic [15:0] seen;
        seen = '0;
        for (int k = 1; k <= video_pkg::H_TOTAL; k++) begin
            @(negedge clk);
            if (k >= PORCH_FIRST && k <= PORCH_LAST) begin
                check_value("luma", luma, video_pkg::LUMA_BLANK);
                seen[chroma] = 1'b1;
            end
            if (k >= FRONT_FIRST) begin
                check_value("chroma", chroma, video_pkg::CHROMA_ZERO);
            end
        end
        if ($countones(seen) < 2) begin
            report_error("no colour burst on chroma during the back porch");
        end
    endtask

    task automatic check_colour_chroma();
        logic [15:0] seen;
        logic [11:0] colour;
        // saturated primaries only
        for (int i = 0; i < video_pkg::PAL_ENTRIES; i++) begin
            case ($urandom() % 3)
                0: colour = 12'hf00;
                1: colour = 12'h0f0;
                default: colour = 12'h00f;
            endcase
            write_palette(8'(i), colour);
        end
        wait_line_start();
        wait_line_start();
        seen = '0;
        for (int k = 1; k <= video_pkg::H_TOTAL; k++) begin
            @(negedge clk);
            if (k >= MID_FIRST && k <= MID_LAST) begin
                seen[chroma] = 1'b1;
            end
        end
        if ($countones(seen) < 2) begin
            report_error("chroma stays at one value across a line of saturated colours");
        end
    endtask

    initial begin
        void'($urandom(76));
        rst      = 1'b1;
        pal_wr   = 1'b0;
        pal_addr = '0;
        pal_data = '0;
        pix_wr   = 1'b0;
        pix_addr = '0;
        pix_data = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        check_line_period();
        check_field_structure();
        load_grey_line();
        check_grey_luma();
        check_hsync_width();
        check_blanking_burst();
        check_colour_chroma();

        $display("closing: %0d errors counted", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
